//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= dual_issue_tb
FILELIST  ?= dual_issue.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dual_issue.f
hw/dual_issue_pkg.sv
hw/issue_scoreboard.sv
hw/issue_ctrl.sv
hw/exec_pipe.sv
hw/dual_issue_top.sv
sim/dual_issue_props.sv
sim/dual_issue_tb.sv

//--- hw/dual_issue_pkg.sv
package dual_issue_pkg;

	// back end shape: two lanes, ex/m1/m2 each
	localparam int NUM_LANES  = 2;
	localparam int NUM_STAGES = 3;

	// stage index into stall and clear vectors
	localparam int STAGE_EX = 0;
	localparam int STAGE_M1 = 1;
	localparam int STAGE_M2 = 2;

	// one-hot position of a freshly issued writer
	localparam logic [2:0] POS_EX = 3'b001;

	// register number, r0 never tracked
	typedef logic [4:0] reg_idx_t;

	// stage at which a source operand is consumed
	typedef enum logic {
		USE_EX = 1'b0,
		USE_M2 = 1'b1
	} use_time_e;

	// stage at which a result first becomes forwardable
	typedef enum logic [1:0] {
		READY_EX = 2'd0,
		READY_M1 = 2'd1,
		READY_M2 = 2'd2
	} ready_time_e;

	// decoded instruction from the front end
	typedef struct packed {
		reg_idx_t          w_reg;
		reg_idx_t [1:0]    r_reg;
		// one bit per source, see use_time_e
		logic [1:0]        use_time;
		ready_time_e       ready_time;
		// lane 0 only: memory, branch, csr
		logic              pipe_one;
		// lane 1 only: multiply
		logic              pipe_two;
		logic              valid;
	} inst_t;

	// per register tracking of an in-flight writer
	// inst_pos moves left each cycle, fwd_ready moves right
	typedef struct packed {
		logic       pipe_sel;
		logic [2:0] inst_pos;
		logic [2:0] fwd_ready;
	} sb_entry_t;

	// one-hot forwarding selects for one operand
	// bit0 of each select is the register file
	typedef struct packed {
		logic       lane;
		logic [3:0] ex_src;
		logic [2:0] m1_src;
		logic [1:0] m2_src;
	} fwd_info_t;

	// write-back strobe, also the content of one pipe stage
	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
	} wb_t;

	// per lane, per stage control bits from the back end
	typedef logic [NUM_LANES-1:0][NUM_STAGES-1:0] stage_vec_t;

	// ready pattern loaded at issue, bit0 ex, bit1 m1, bit2 m2
	// later ready time means fewer consumer stages can take it yet
	function automatic logic [2:0] ready_pattern(ready_time_e rt);
		case (rt)
			READY_EX: return 3'b111;
			READY_M1: return 3'b110;
			default:  return 3'b100;
		endcase
	endfunction

endpackage

//--- hw/dual_issue_top.sv
`timescale 1ns/1ns

module dual_issue_top import dual_issue_pkg::*; #(
	parameter int NUM_REGS = 32
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  inst_t [1:0]          inst_i,
	input  logic                 stall_i,
	input  logic                 flush_i,
	input  stage_vec_t           stall_vec_i,
	input  stage_vec_t           clr_vec_i,
	output logic [1:0]           issue_o,
	output logic                 revert_o,
	output fwd_info_t [1:0][1:0] fwd_o,
	output wb_t [1:0]            wb_o
);

	// scoreboard state seen by the controller
	sb_entry_t [NUM_REGS-1:0] sb;

	// controller decides from this cycle's scoreboard
	issue_ctrl u_issue_ctrl (
		.inst_i   (inst_i),
		.sb_i     (sb),
		.stall_i  (stall_i),
		.flush_i  (flush_i),
		.issue_o  (issue_o),
		.revert_o (revert_o),
		.fwd_o    (fwd_o)
	);

	issue_scoreboard #(
		.NUM_REGS (NUM_REGS)
	) u_issue_scoreboard (
		.clk         (clk),
		.rst_n       (rst_n),
		.inst_i      (inst_i),
		.issue_i     (issue_o),
		.revert_i    (revert_o),
		.stall_vec_i (stall_vec_i),
		.clr_vec_i   (clr_vec_i),
		.sb_o        (sb)
	);

	// back end model, carries writers to write-back
	exec_pipe u_exec_pipe (
		.clk         (clk),
		.rst_n       (rst_n),
		.inst_i      (inst_i),
		.issue_i     (issue_o),
		.revert_i    (revert_o),
		.stall_vec_i (stall_vec_i),
		.clr_vec_i   (clr_vec_i),
		.wb_o        (wb_o)
	);

endmodule

//--- hw/exec_pipe.sv
`timescale 1ns/1ns

module exec_pipe import dual_issue_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  inst_t [1:0] inst_i,
	input  logic [1:0]  issue_i,
	input  logic        revert_i,
	input  stage_vec_t  stall_vec_i,
	input  stage_vec_t  clr_vec_i,
	output wb_t [1:0]   wb_o
);

	// stage contents, [lane][stage]
	wb_t [NUM_LANES-1:0][NUM_STAGES-1:0] stage_q;
	wb_t [NUM_LANES-1:0][NUM_STAGES-1:0] stage_d;

	// instruction entering ex of each lane
	wb_t [NUM_LANES-1:0] issued;

	// what a stage hands to the next one
	// held or cleared stage sends a bubble
	function automatic wb_t advance(wb_t src, logic hold, logic drop);
		wb_t r;
		r = src;
		if (hold || drop) begin
			r.valid = 1'b0;
		end
		return r;
	endfunction

	always_comb begin
		logic [NUM_STAGES-1:0] stl;
		logic [NUM_STAGES-1:0] clr;
		logic                  src;
		for (int l = 0; l < NUM_LANES; l++) begin
			stl = stall_vec_i[l];
			clr = clr_vec_i[l];

			// lane l takes instruction l ^ revert
			src = 1'(l) ^ revert_i;
			issued[l].valid = issue_i[src];
			issued[l].rd    = inst_i[src].w_reg;

			// ex
			if (stl[STAGE_EX]) begin
				stage_d[l][STAGE_EX] = stage_q[l][STAGE_EX];
			end else begin
				stage_d[l][STAGE_EX] = issued[l];
			end

			// m1
			if (stl[STAGE_M1]) begin
				stage_d[l][STAGE_M1] = stage_q[l][STAGE_M1];
			end else begin
				stage_d[l][STAGE_M1] = advance(stage_q[l][STAGE_EX], stl[STAGE_EX],
					clr[STAGE_EX]);
			end

			// m2
			if (stl[STAGE_M2]) begin
				stage_d[l][STAGE_M2] = stage_q[l][STAGE_M2];
			end else begin
				stage_d[l][STAGE_M2] = advance(stage_q[l][STAGE_M1], stl[STAGE_M1],
					clr[STAGE_M1]);
			end

			// write back as m2 leaves, r0 writers travel silently
			wb_o[l] = advance(stage_q[l][STAGE_M2], stl[STAGE_M2], clr[STAGE_M2]);
			if (wb_o[l].rd == '0) begin
				wb_o[l].valid = 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			stage_q <= '0;
		end else begin
			stage_q <= stage_d;
		end
	end

endmodule

//--- hw/issue_ctrl.sv
`timescale 1ns/1ns

module issue_ctrl import dual_issue_pkg::*; (
	input  inst_t [1:0]                              inst_i,
	input  sb_entry_t [(1 << $bits(reg_idx_t))-1:0] sb_i,
	input  logic                                     stall_i,
	input  logic                                     flush_i,
	output logic [1:0]                               issue_o,
	output logic                                     revert_o,
	output fwd_info_t [1:0][1:0]                     fwd_o
);

	// scoreboard entry of each source, [inst][operand]
	sb_entry_t [1:0][1:0] src_e;

	logic [1:0] raw_hit;
	logic       pair_data_hit;
	logic       pair_pipe_hit;
	logic       issue_first;
	logic       issue_second;

	// true when a source has a writer in flight that cannot serve it yet
	// ex use needs the ex ready bit, m2 use takes any ready bit
	function automatic logic raw_conflict(inst_t inst, sb_entry_t [1:0] e);
		logic hit;
		hit = 1'b0;
		for (int j = 0; j < 2; j++) begin
			if (e[j].inst_pos != '0) begin
				if (inst.use_time[j] == USE_EX) begin
					hit |= ~e[j].fwd_ready[0];
				end else begin
					hit |= ~(|e[j].fwd_ready);
				end
			end
		end
		return hit;
	endfunction

	// position masked by readiness at each consumer stage
	// nothing matches means register file
	function automatic fwd_info_t fwd_decode(sb_entry_t e);
		fwd_info_t f;
		f.lane        = e.pipe_sel;
		f.ex_src[3:1] = e.inst_pos & {3{e.fwd_ready[0]}};
		f.ex_src[0]   = ~|f.ex_src[3:1];
		f.m1_src[2:1] = e.inst_pos[1:0] & {2{e.fwd_ready[1]}};
		f.m1_src[0]   = ~|f.m1_src[2:1];
		f.m2_src[1]   = e.inst_pos[0] & e.fwd_ready[2];
		f.m2_src[0]   = ~f.m2_src[1];
		return f;
	endfunction

	for (genvar k = 0; k < 2; k++) begin : g_inst
		for (genvar j = 0; j < 2; j++) begin : g_src
			assign src_e[k][j] = sb_i[inst_i[k].r_reg[j]];
			assign fwd_o[k][j] = fwd_decode(src_e[k][j]);
		end
		assign raw_hit[k] = raw_conflict(inst_i[k], src_e[k]);
	end

	// second one may not touch what the first one writes
	// keeps the pair free of ordering inside the issue group
	assign pair_data_hit = (inst_i[0].w_reg != '0) &&
		((inst_i[0].w_reg == inst_i[1].r_reg[0]) ||
		 (inst_i[0].w_reg == inst_i[1].r_reg[1]) ||
		 (inst_i[0].w_reg == inst_i[1].w_reg));

	// only one restricted lane user of each kind per pair
	assign pair_pipe_hit = (inst_i[0].pipe_one & inst_i[1].pipe_one) |
		(inst_i[0].pipe_two & inst_i[1].pipe_two);

	// strictly in order, the second only rides with the first
	assign issue_first = inst_i[0].valid & ~stall_i & ~flush_i & ~raw_hit[0];
	assign issue_second = issue_first & inst_i[1].valid & ~raw_hit[1] &
		~pair_data_hit & ~pair_pipe_hit;

	assign issue_o = {issue_second, issue_first};

	// swap lanes when a restricted instruction sits in the wrong slot
	assign revert_o = (issue_first & inst_i[0].pipe_two) |
		(issue_second & inst_i[1].pipe_one);

endmodule

//--- hw/issue_scoreboard.sv
`timescale 1ns/1ns

module issue_scoreboard import dual_issue_pkg::*; #(
	parameter int NUM_REGS = 32
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  inst_t [1:0]              inst_i,
	input  logic [1:0]               issue_i,
	input  logic                     revert_i,
	input  stage_vec_t               stall_vec_i,
	input  stage_vec_t               clr_vec_i,
	output sb_entry_t [NUM_REGS-1:0] sb_o
);

	sb_entry_t [NUM_REGS-1:0] sb_q;
	sb_entry_t [NUM_REGS-1:0] sb_d;

	// next state of every entry
	// priority from low to high: shift, clear, stall, issue
	always_comb begin
		sb_entry_t cur;
		sb_entry_t nxt;
		for (int i = 0; i < NUM_REGS; i++) begin
			cur = sb_q[i];

			// default shift, position left and readiness right
			nxt.pipe_sel  = cur.pipe_sel;
			nxt.inst_pos  = {cur.inst_pos[1:0], 1'b0};
			nxt.fwd_ready = {1'b0, cur.fwd_ready[2:1]};

			// cleared writer still drains, but never forwards again
			if (|(cur.inst_pos & clr_vec_i[cur.pipe_sel])) begin
				nxt.fwd_ready = '0;
			end

			// stalled stage keeps position and readiness
			if (|(cur.inst_pos & stall_vec_i[cur.pipe_sel])) begin
				nxt = cur;
			end

			// new writer takes the entry over
			// k = 1 comes last, so the younger write wins
			for (int k = 0; k < 2; k++) begin
				if (issue_i[k] && inst_i[k].w_reg == reg_idx_t'(i)) begin
					nxt.pipe_sel  = 1'(k) ^ revert_i;
					nxt.inst_pos  = POS_EX;
					nxt.fwd_ready = ready_pattern(inst_i[k].ready_time);
				end
			end

			// r0 is hardwired, never a dependency
			if (i == 0) begin
				nxt = '0;
			end

			sb_d[i] = nxt;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sb_q <= '0;
		end else begin
			sb_q <= sb_d;
		end
	end

	assign sb_o = sb_q;

endmodule

//--- sim/dual_issue_props.sv
`timescale 1ns/1ns

module dual_issue_props import dual_issue_pkg::*; (
	input logic       clk,
	input logic       rst_n,
	input logic [1:0] issue_o,
	input logic       stall_i,
	input logic       revert_o,
	input wb_t [1:0]  wb_o
);

	// second never goes without the first
	issue_in_order: assert property (@(posedge clk) disable iff (!rst_n)
		issue_o != 2'b10)
		else $error("issue strobe 10 seen");

	// front-end hold blocks issue
	no_issue_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
		stall_i |-> issue_o == 2'b00)
		else $error("issue under stall");

	// lane swap only means something with an issue
	revert_needs_issue: assert property (@(posedge clk) disable iff (!rst_n)
		revert_o |-> issue_o != 2'b00)
		else $error("revert without issue");

	// r0 writers travel silently
	wb0_not_r0: assert property (@(posedge clk) disable iff (!rst_n)
		wb_o[0].valid |-> wb_o[0].rd != 5'd0)
		else $error("write-back to r0 on lane 0");

	wb1_not_r0: assert property (@(posedge clk) disable iff (!rst_n)
		wb_o[1].valid |-> wb_o[1].rd != 5'd0)
		else $error("write-back to r0 on lane 1");

endmodule

//--- sim/dual_issue_tb.sv
`timescale 1ns/1ns

module dual_issue_tb import dual_issue_pkg::*; ();

	localparam int          RESET_CYCLES = 8;
	localparam int          TEST_CYCLES  = 3000;
	localparam int          CLK_PERIOD   = 20;
	localparam int          MARGIN       = 50;
	localparam logic [31:0] SEED         = 32'hf69e_6e21;

	// expected outputs of one cycle
	typedef struct packed {
		logic [1:0]           issue;
		logic                 revert;
		fwd_info_t [1:0][1:0] fwd;
		wb_t [1:0]            wb;
	} expect_t;

	logic                 clk;
	logic                 rst_n;
	inst_t [1:0]          inst_i;
	logic                 stall_i;
	logic                 flush_i;
	stage_vec_t           stall_vec_i;
	stage_vec_t           clr_vec_i;
	logic [1:0]           issue_o;
	logic                 revert_o;
	fwd_info_t [1:0][1:0] fwd_o;
	wb_t [1:0]            wb_o;

	// scoreboard copy and pipe copy of the model
	logic       m_lane [32];
	logic [2:0] m_pos  [32];
	logic [2:0] m_rdy  [32];
	wb_t        m_stage [2][3];

	// issue seen at the last edge is what the front end consumed
	logic [1:0] last_issue;

	dual_issue_top #(
		.NUM_REGS (32)
	) DUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.inst_i      (inst_i),
		.stall_i     (stall_i),
		.flush_i     (flush_i),
		.stall_vec_i (stall_vec_i),
		.clr_vec_i   (clr_vec_i),
		.issue_o     (issue_o),
		.revert_o    (revert_o),
		.fwd_o       (fwd_o),
		.wb_o        (wb_o)
	);

	bind dual_issue_top dual_issue_props u_props (
		.clk      (clk),
		.rst_n    (rst_n),
		.issue_o  (issue_o),
		.stall_i  (stall_i),
		.revert_o (revert_o),
		.wb_o     (wb_o)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic report_error(string msg);
		$display("** Error at %0t ns: %s", $time, msg);
		$display("Verification failed");
		$fatal(1, "stopping on first mismatch");
	endtask

	task automatic check_issue(logic [1:0] got, logic [1:0] exp, logic got_rev, logic exp_rev);
		if (got !== exp || got_rev !== exp_rev) begin
			report_error($sformatf("issue %b revert %b, expected %b revert %b",
				got, got_rev, exp, exp_rev));
		end
	endtask

	task automatic check_fwd(fwd_info_t got, fwd_info_t exp, int k, int j);
		if (got !== exp) begin
			report_error($sformatf("fwd inst %0d src %0d is %h, expected %h",
				k, j, got, exp));
		end
	endtask

	task automatic check_wb(wb_t got, wb_t exp, int lane);
		// rd only matters while the strobe is valid
		if (got.valid !== exp.valid || (exp.valid && got.rd !== exp.rd)) begin
			report_error($sformatf("wb lane %0d is %b/%0d, expected %b/%0d",
				lane, got.valid, got.rd, exp.valid, exp.rd));
		end
	endtask

	// a source is blocked by a writer in flight that is not ready for its use
	function automatic logic blocked(inst_t inst);
		reg_idx_t r;
		logic     b;
		b = 1'b0;
		for (int j = 0; j < 2; j++) begin
			r = inst.r_reg[j];
			if (m_pos[r] != 3'b000) begin
				if (inst.use_time[j]) begin
					b = b | (m_rdy[r] == 3'b000);
				end else begin
					b = b | ~m_rdy[r][0];
				end
			end
		end
		return b;
	endfunction

	// expected outputs from model state and current inputs
	function automatic expect_t predict();
		expect_t  e;
		logic     first;
		logic     second;
		logic     dep;
		reg_idx_t r;
		logic [2:0] h;
		first = inst_i[0].valid && !stall_i && !flush_i && !blocked(inst_i[0]);
		dep = inst_i[0].w_reg != 5'd0 && (inst_i[0].w_reg == inst_i[1].w_reg ||
			inst_i[0].w_reg == inst_i[1].r_reg[0] ||
			inst_i[0].w_reg == inst_i[1].r_reg[1]);
		second = first && inst_i[1].valid && !blocked(inst_i[1]) && !dep &&
			!(inst_i[0].pipe_one && inst_i[1].pipe_one) &&
			!(inst_i[0].pipe_two && inst_i[1].pipe_two);
		e.issue  = {second, first};
		e.revert = (first && inst_i[0].pipe_two) || (second && inst_i[1].pipe_one);
		for (int k = 0; k < 2; k++) begin
			for (int j = 0; j < 2; j++) begin
				r = inst_i[k].r_reg[j];
				e.fwd[k][j].lane = m_lane[r];
				// each consumer stage sees the writer's position if ready there
				h = m_pos[r] & {3{m_rdy[r][0]}};
				e.fwd[k][j].ex_src = {h, h == 3'b000};
				h = m_pos[r] & {3{m_rdy[r][1]}};
				e.fwd[k][j].m1_src = {h[1:0], h[1:0] == 2'b00};
				h = m_pos[r] & {3{m_rdy[r][2]}};
				e.fwd[k][j].m2_src = {h[0], !h[0]};
			end
		end
		for (int l = 0; l < 2; l++) begin
			e.wb[l].rd    = m_stage[l][2].rd;
			e.wb[l].valid = m_stage[l][2].valid && !stall_vec_i[l][2] &&
				!clr_vec_i[l][2] && m_stage[l][2].rd != 5'd0;
		end
		return e;
	endfunction

	task automatic reset_model();
		for (int i = 0; i < 32; i++) begin
			m_lane[i] = 1'b0;
			m_pos[i]  = 3'b000;
			m_rdy[i]  = 3'b000;
		end
		for (int l = 0; l < 2; l++) begin
			for (int s = 0; s < 3; s++) begin
				m_stage[l][s] = '0;
			end
		end
	endtask

	// advance scoreboard and pipe copies by one edge
	task automatic step_model(logic [1:0] iss, logic rev);
		logic ln;
		logic [2:0] rdy;
		for (int i = 1; i < 32; i++) begin
			ln = m_lane[i];
			if ((m_pos[i] & stall_vec_i[ln]) == 3'b000) begin
				rdy = (m_pos[i] & clr_vec_i[ln]) != 3'b000 ? 3'b000 : m_rdy[i];
				m_rdy[i] = rdy >> 1;
				m_pos[i] = m_pos[i] << 1;
			end
			for (int k = 0; k < 2; k++) begin
				if (iss[k] && inst_i[k].w_reg == 5'(i)) begin
					m_lane[i] = 1'(k) ^ rev;
					m_pos[i]  = 3'b001;
					// consumer stages at or past the ready stage can take the result
					for (int s = 0; s < 3; s++) begin
						m_rdy[i][s] = s >= int'(inst_i[k].ready_time);
					end
				end
			end
		end
		for (int l = 0; l < 2; l++) begin
			// back to front so each stage reads the old value ahead of it
			for (int s = 2; s > 0; s--) begin
				if (!stall_vec_i[l][s]) begin
					m_stage[l][s] = m_stage[l][s-1];
					if (stall_vec_i[l][s-1] || clr_vec_i[l][s-1]) begin
						m_stage[l][s].valid = 1'b0;
					end
				end
			end
			if (!stall_vec_i[l][0]) begin
				m_stage[l][0].valid = iss[1'(l) ^ rev];
				m_stage[l][0].rd    = inst_i[1'(l) ^ rev].w_reg;
			end
		end
	endtask

	// small register pool so conflicts are common
	function automatic inst_t rand_inst();
		inst_t   n;
		int unsigned p;
		n.w_reg      = reg_idx_t'($urandom_range(5));
		n.r_reg[0]   = reg_idx_t'($urandom_range(5));
		n.r_reg[1]   = reg_idx_t'($urandom_range(5));
		n.use_time   = 2'($urandom_range(3));
		n.ready_time = ready_time_e'(2'($urandom_range(2)));
		p            = $urandom_range(7);
		n.pipe_one   = p == 0;
		n.pipe_two   = p == 1;
		n.valid      = $urandom_range(9) != 0;
		return n;
	endfunction

	function automatic logic [2:0] rand_stall();
		case ($urandom_range(15))
			0: return 3'b001;
			1: return 3'b011;
			2: return 3'b111;
			default: return 3'b000;
		endcase
	endfunction

	always @(posedge clk) begin
		expect_t e;
		if (!rst_n) begin
			reset_model();
			last_issue <= 2'b00;
		end else begin
			e = predict();
			check_issue(issue_o, e.issue, revert_o, e.revert);
			for (int k = 0; k < 2; k++) begin
				for (int j = 0; j < 2; j++) begin
					check_fwd(fwd_o[k][j], e.fwd[k][j], k, j);
				end
				check_wb(wb_o[k], e.wb[k], k);
			end
			last_issue <= e.issue;
			step_model(e.issue, e.revert);
		end
	end

	initial begin
		#((RESET_CYCLES + TEST_CYCLES + MARGIN) * CLK_PERIOD);
		$display("timeout: the run did not reach its end");
		$display("Verification failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		void'($urandom(SEED));
		clk           = 1'b0;
		rst_n         = 1'b0;
		inst_i        = '0;
		stall_i       = 1'b0;
		flush_i       = 1'b0;
		stall_vec_i   = '0;
		clr_vec_i     = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		// first cycle out of reset has nothing valid to issue
		@(negedge clk);
		// independent pair right after the idle cycle
		inst_i[0] = '{w_reg: 5'd1, r_reg: {5'd3, 5'd4}, use_time: 2'b00,
			ready_time: READY_EX, pipe_one: 1'b0, pipe_two: 1'b0, valid: 1'b1};
		inst_i[1] = '{w_reg: 5'd2, r_reg: {5'd5, 5'd6}, use_time: 2'b00,
			ready_time: READY_M2, pipe_one: 1'b0, pipe_two: 1'b0, valid: 1'b1};
		for (int c = 0; c < TEST_CYCLES; c++) begin
			@(negedge clk);
			// consumed instructions leave and the older one stays in slot 0
			if (flush_i || last_issue == 2'b11) begin
				inst_i[0] = rand_inst();
				inst_i[1] = rand_inst();
			end else if (last_issue == 2'b01) begin
				inst_i[0] = inst_i[1];
				inst_i[1] = rand_inst();
			end
			for (int l = 0; l < 2; l++) begin
				stall_vec_i[l] = rand_stall();
				for (int s = 0; s < 3; s++) begin
					clr_vec_i[l][s] = $urandom_range(31) == 0;
				end
			end
			stall_i = stall_vec_i[0][0] || stall_vec_i[1][0] || $urandom_range(15) == 0;
			flush_i = $urandom_range(31) == 0;
		end
		@(negedge clk);
		$display("Verification passed");
		$finish;
	end

endmodule
